// File: rtl/ecc_err_counters.sv
// Bank of four 32-bit ECC error counters that wrap modulo 2^32
// A software load of a counter wins over its increment in the same cycle
// and the flags of that cycle are then lost for that counter only
`timescale 1ns/1ns

module ecc_err_counters
  import ecc_mgr_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  ecc_err_t              err_i,
  input  logic                  load_i,
  input  reg_addr_t             load_sel_i,
  input  err_cnt_t              load_val_i,
  output err_cnt_t [N_CNT-1:0]  counts_o
);

  // Number of flags raised in this cycle for each flag vector
  logic [DATA_POP_W-1:0] data_corr_num;
  logic [DATA_POP_W-1:0] data_uncorr_num;
  logic [META_POP_W-1:0] meta_corr_num;
  logic [META_POP_W-1:0] meta_uncorr_num;

  // Increments widened to counter size, indexed by register address
  err_cnt_t [N_CNT-1:0] inc;
  // Update enable of each counter, high when any of its flags is set
  logic     [N_CNT-1:0] upd_en;

  err_cnt_t [N_CNT-1:0] cnt_q;

  ecc_err_popcount #(
    .WIDTH   ( DATA_ERR_W )
  ) i_pop_data_corr (
    .data_i  ( err_i.data_corr ),
    .count_o ( data_corr_num   )
  );

  ecc_err_popcount #(
    .WIDTH   ( DATA_ERR_W )
  ) i_pop_data_uncorr (
    .data_i  ( err_i.data_uncorr ),
    .count_o ( data_uncorr_num   )
  );

  ecc_err_popcount #(
    .WIDTH   ( META_ERR_W )
  ) i_pop_meta_corr (
    .data_i  ( err_i.meta_corr ),
    .count_o ( meta_corr_num   )
  );

  // Fed from the uncorrectable metadata flags, not the correctable ones
  ecc_err_popcount #(
    .WIDTH   ( META_ERR_W )
  ) i_pop_meta_uncorr (
    .data_i  ( err_i.meta_uncorr ),
    .count_o ( meta_uncorr_num   )
  );

  // Route each popcount to the counter slot given by the register map
  always_comb begin
    inc[REG_DATA_CORR]   = err_cnt_t'(data_corr_num);
    inc[REG_DATA_UNCORR] = err_cnt_t'(data_uncorr_num);
    inc[REG_META_CORR]   = err_cnt_t'(meta_corr_num);
    inc[REG_META_UNCORR] = err_cnt_t'(meta_uncorr_num);

    upd_en[REG_DATA_CORR]   = |err_i.data_corr;
    upd_en[REG_DATA_UNCORR] = |err_i.data_uncorr;
    upd_en[REG_META_CORR]   = |err_i.meta_corr;
    upd_en[REG_META_UNCORR] = |err_i.meta_uncorr;
  end

  // Flags seen before an edge are added at that edge
  // A counter without flags holds its value
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        if (load_i && (load_sel_i == reg_addr_t'(i))) begin
          // Software load takes this counter's slot for the cycle
          cnt_q[i] <= load_val_i;
        end else if (upd_en[i]) begin
          // Plain 32-bit add, overflow wraps around
          cnt_q[i] <= cnt_q[i] + inc[i];
        end
      end
    end
  end

  assign counts_o = cnt_q;

endmodule

// File: rtl/ecc_err_popcount.sv
// Combinational count of the set bits in a flag vector
// WIDTH must be at least 2, the result is one bit wider than log2 of WIDTH
`timescale 1ns/1ns

module ecc_err_popcount #(
  parameter int unsigned WIDTH = 8
) (
  input  logic [WIDTH-1:0]       data_i,
  output logic [$clog2(WIDTH):0] count_o
);

  // Ripple sum over all bits
  // The widths used here are small, so a plain adder chain is short enough
  always_comb begin
    count_o = '0;
    for (int i = 0; i < WIDTH; i++) begin
      // Each flag is zero-extended to the result width before it is added
      count_o = count_o + {{$clog2(WIDTH){1'b0}}, data_i[i]};
    end
  end

endmodule

// File: rtl/ecc_mgr_pkg.sv
// Shared widths, register map and bus types of the ECC error manager
// The register word address covers exactly the four counters, so no address is unmapped
// Counters are plain 32-bit values and wrap modulo 2^32
package ecc_mgr_pkg;

  // ECC chunks inside one data word
  localparam int unsigned N_CHUNK  = 4;
  // Number of parallel data and metadata ports checked by the decoders
  localparam int unsigned PAR_DATA = 2;
  localparam int unsigned PAR_META = 2;

  // One flag per data chunk of every data port
  localparam int unsigned DATA_ERR_W = PAR_DATA * N_CHUNK;
  // One flag per metadata port
  localparam int unsigned META_ERR_W = PAR_META;

  // Width of the per-cycle flag counts of each vector
  localparam int unsigned DATA_POP_W = $clog2(DATA_ERR_W) + 1;
  localparam int unsigned META_POP_W = $clog2(META_ERR_W) + 1;

  localparam int unsigned CNT_W  = 32;
  localparam int unsigned ADDR_W = 2;
  // Number of counters reachable from the register port
  localparam int unsigned N_CNT  = 2 ** ADDR_W;

  typedef logic [DATA_ERR_W-1:0] data_err_t;
  typedef logic [META_ERR_W-1:0] meta_err_t;
  typedef logic [CNT_W-1:0]      err_cnt_t;
  typedef logic [ADDR_W-1:0]     reg_addr_t;

  // Register word addresses of the counters
  localparam reg_addr_t REG_DATA_CORR   = 2'd0;
  localparam reg_addr_t REG_DATA_UNCORR = 2'd1;
  localparam reg_addr_t REG_META_CORR   = 2'd2;
  localparam reg_addr_t REG_META_UNCORR = 2'd3;

  // Master side of the four-phase register handshake
  typedef struct packed {
    logic      req;
    logic      we;
    reg_addr_t addr;
    err_cnt_t  wdata;
  } reg_req_t;

  // Slave side, rdata is valid while ack is high
  typedef struct packed {
    logic     ack;
    err_cnt_t rdata;
  } reg_rsp_t;

  // All decoder flags of one cycle
  typedef struct packed {
    data_err_t data_corr;
    data_err_t data_uncorr;
    meta_err_t meta_corr;
    meta_err_t meta_uncorr;
  } ecc_err_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    WAIT_REL
  } reg_state_e;

endpackage

// File: rtl/ecc_mgr_top.sv
// Top level of the ECC error manager
// Decoder flags on err_i are sampled on every rising edge of clk_i
// The counters are read and written through the four-phase register port
`timescale 1ns/1ns

module ecc_mgr_top
  import ecc_mgr_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  // Register port from the bus master
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  // Correctable and uncorrectable flags from the data and metadata decoders
  input  ecc_err_t err_i
);

  // Load path from the register FSM to the counter bank
  logic      load;
  reg_addr_t load_sel;
  err_cnt_t  load_val;

  // Current counter values, one slot per register address
  err_cnt_t [N_CNT-1:0] counts;

  // Handshake engine, it also picks the read data from the counter bank
  ecc_reg_fsm i_reg_fsm (
    .clk_i      ( clk_i     ),
    .rst_i      ( rst_i     ),
    .reg_req_i  ( reg_req_i ),
    .reg_rsp_o  ( reg_rsp_o ),
    .counts_i   ( counts    ),
    .load_o     ( load      ),
    .load_sel_o ( load_sel  ),
    .load_val_o ( load_val  )
  );

  // Error counters, these keep counting while an access is in progress
  ecc_err_counters i_err_counters (
    .clk_i      ( clk_i    ),
    .rst_i      ( rst_i    ),
    .err_i      ( err_i    ),
    .load_i     ( load     ),
    .load_sel_i ( load_sel ),
    .load_val_i ( load_val ),
    .counts_o   ( counts   )
  );

endmodule

// File: rtl/ecc_reg_fsm.sv
// Four-phase req/ack register slave in front of the counter bank
// The master must keep we, addr and wdata stable while req is high
// Ack comes two edges after req is first sampled and falls one edge after req drops
`timescale 1ns/1ns

module ecc_reg_fsm
  import ecc_mgr_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  reg_req_t              reg_req_i,
  output reg_rsp_t              reg_rsp_o,
  input  err_cnt_t [N_CNT-1:0]  counts_i,
  output logic                  load_o,
  output reg_addr_t             load_sel_o,
  output err_cnt_t              load_val_o
);

  reg_state_e state_q;
  reg_state_e state_d;

  // Response is fully registered so ack cannot glitch
  logic     ack_q;
  err_cnt_t rdata_q;

  // Next-state logic of the handshake
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        // A new access starts as soon as req is seen
        if (reg_req_i.req) begin
          state_d = ACCESS;
        end
      end
      ACCESS: begin
        // The counter value is captured on the way out of this state
        state_d = WAIT_REL;
      end
      WAIT_REL: begin
        // Ack stays up for as long as the master holds req
        if (!reg_req_i.req) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ACCESS) begin
        // For a write this returns the value that was just loaded
        rdata_q <= counts_i[reg_req_i.addr];
        ack_q   <= 1'b1;
      end else if ((state_q == WAIT_REL) && !reg_req_i.req) begin
        ack_q <= 1'b0;
      end
    end
  end

  // The load hits the counters on the same edge that moves IDLE to ACCESS
  // It lasts one cycle because the FSM leaves IDLE at that edge
  assign load_o     = (state_q == IDLE) && reg_req_i.req && reg_req_i.we;
  assign load_sel_o = reg_req_i.addr;
  assign load_val_o = reg_req_i.wdata;

  always_comb begin
    reg_rsp_o.ack   = ack_q;
    reg_rsp_o.rdata = rdata_q;
  end

endmodule

// File: run.sh
#!/bin/sh
# Builds the ECC error manager testbench with Verilator and runs it.
# Pass or fail is taken from the simulation log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_ecc_mgr

verilator --binary --timing --timescale 1ns/1ns \
  -f tb.f --top-module tb_ecc_mgr \
  --Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status, see $LOG"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  echo "PASS, see $LOG"
  exit 0
else
  echo "FAIL, see $LOG"
  exit 1
fi

// File: tb.f
rtl/ecc_mgr_pkg.sv
rtl/ecc_err_popcount.sv
rtl/ecc_err_counters.sv
rtl/ecc_reg_fsm.sv
rtl/ecc_mgr_top.sv
test/tb_ecc_mgr.sv

// File: test/tb_ecc_mgr.sv
// Directed testbench for the ECC error manager top level
// Flags are driven only while no register access runs, except during the
// back-pressure test, where the held access is a read and cannot collide with a load
`timescale 1ns/1ns

module tb_ecc_mgr
  import ecc_mgr_pkg::*;
;

  // Run limit, the tests need roughly 700 cycles in total
  localparam int unsigned TIMEOUT_CYCLES   = 3000;
  // Upper bound on the wait for any ack edge
  localparam int unsigned ACK_WAIT_MAX     = 16;
  // Req is seen one edge after it is driven and ack rises two edges after that
  localparam int unsigned ACK_LATENCY      = 3;
  // Req low is seen one edge after it is driven and ack falls at that same edge
  localparam int unsigned ACK_FALL_LATENCY = 2;
  localparam int unsigned HOLD_CYCLES      = 20;
  localparam int unsigned RAND_CYCLES      = 200;

  logic     clk;
  logic     rst;
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;
  ecc_err_t err;

  // Expected counter values, indexed by register address
  err_cnt_t    exp_cnt [N_CNT];
  int unsigned errors;
  int unsigned checks;
  int unsigned cycle_cnt;
  integer      seed;

  ecc_mgr_top dut_i (
    .clk_i     ( clk     ),
    .rst_i     ( rst     ),
    .reg_req_i ( reg_req ),
    .reg_rsp_o ( reg_rsp ),
    .err_i     ( err     )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Ends a run that hangs
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic int unsigned count_ones(input logic [31:0] v);
    int unsigned n;
    n = 0;
    for (int i = 0; i < 32; i++) begin
      if (v[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic string cnt_name(input reg_addr_t a);
    case (a)
      REG_DATA_CORR:   return "data_corr count";
      REG_DATA_UNCORR: return "data_uncorr count";
      REG_META_CORR:   return "meta_corr count";
      default:         return "meta_uncorr count";
    endcase
  endfunction

  task automatic check_val(input string name, input err_cnt_t expv, input err_cnt_t actv);
    checks++;
    if (actv !== expv) begin
      $display("** Error %s: expected 0x%08h, got 0x%08h", name, expv, actv);
      errors++;
    end
  endtask

  // Drives one cycle of flags and adds their bit counts to the model
  task automatic apply_flags(input ecc_err_t e);
    @(posedge clk);
    err <= e;
    exp_cnt[REG_DATA_CORR]   = exp_cnt[REG_DATA_CORR] + count_ones(32'(e.data_corr));
    exp_cnt[REG_DATA_UNCORR] = exp_cnt[REG_DATA_UNCORR] + count_ones(32'(e.data_uncorr));
    exp_cnt[REG_META_CORR]   = exp_cnt[REG_META_CORR] + count_ones(32'(e.meta_corr));
    exp_cnt[REG_META_UNCORR] = exp_cnt[REG_META_UNCORR] + count_ones(32'(e.meta_uncorr));
  endtask

  task automatic clear_flags();
    @(posedge clk);
    err <= '0;
  endtask

  // Waits on falling edges until ack reaches the given level
  task automatic wait_ack(input logic level, output int unsigned cycles);
    cycles = 0;
    @(negedge clk);
    cycles = 1;
    while ((reg_rsp.ack !== level) && (cycles < ACK_WAIT_MAX)) begin
      @(negedge clk);
      cycles++;
    end
    if (reg_rsp.ack !== level) begin
      $display("Handshake error: ack did not go %s within %0d cycles",
               level ? "high" : "low", ACK_WAIT_MAX);
      errors++;
    end
  endtask

  // One complete four-phase access, rdata is taken while ack is high
  task automatic reg_access(input logic we, input reg_addr_t addr,
                            input err_cnt_t wdata, output err_cnt_t rdata);
    reg_req_t    r;
    int unsigned lat;
    r.req   = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.wdata = wdata;
    @(negedge clk);
    if (reg_rsp.ack !== 1'b0) begin
      $display("Handshake error: ack is high before req is raised");
      errors++;
    end
    @(posedge clk);
    reg_req <= r;
    wait_ack(1'b1, lat);
    if (lat != ACK_LATENCY) begin
      $display("Handshake error: ack rose %0d cycles after req, expected %0d",
               lat, ACK_LATENCY);
      errors++;
    end
    rdata = reg_rsp.rdata;
    @(posedge clk);
    reg_req <= '0;
    wait_ack(1'b0, lat);
    if (lat != ACK_FALL_LATENCY) begin
      $display("Handshake error: ack fell %0d cycles after req dropped, expected %0d",
               lat, ACK_FALL_LATENCY);
      errors++;
    end
  endtask

  task automatic reg_write(input reg_addr_t addr, input err_cnt_t val);
    err_cnt_t rd;
    reg_access(1'b1, addr, val, rd);
    exp_cnt[addr] = val;
  endtask

  task automatic read_check(input reg_addr_t addr);
    err_cnt_t rd;
    reg_access(1'b0, addr, '0, rd);
    check_val(cnt_name(addr), exp_cnt[addr], rd);
  endtask

  task automatic read_all();
    for (int i = 0; i < N_CNT; i++) begin
      read_check(reg_addr_t'(i));
    end
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_val("ack", '0, err_cnt_t'(reg_rsp.ack));
    check_val("rdata", '0, reg_rsp.rdata);
    read_all();
  endtask

  // Random data flags, the metadata counters must stay at zero
  task automatic test_data_random();
    ecc_err_t    e;
    logic [31:0] rnd_c;
    logic [31:0] rnd_u;
    repeat (RAND_CYCLES) begin
      rnd_c         = $random(seed);
      rnd_u         = $random(seed);
      e             = '0;
      e.data_corr   = rnd_c[DATA_ERR_W-1:0];
      e.data_uncorr = rnd_u[DATA_ERR_W-1:0];
      apply_flags(e);
    end
    clear_flags();
    read_all();
  endtask

  // Random metadata flags, each counter must see only its own vector
  task automatic test_meta_random();
    ecc_err_t    e;
    logic [31:0] rnd_c;
    logic [31:0] rnd_u;
    repeat (RAND_CYCLES) begin
      rnd_c         = $random(seed);
      rnd_u         = $random(seed);
      e             = '0;
      e.meta_corr   = rnd_c[META_ERR_W-1:0];
      e.meta_uncorr = rnd_u[META_ERR_W-1:0];
      apply_flags(e);
    end
    clear_flags();
    read_all();
  endtask

  task automatic test_loads();
    err_cnt_t vals [N_CNT];
    err_cnt_t rd;
    ecc_err_t e;
    vals[0] = 32'h1234_5678;
    vals[1] = 32'hDEAD_BEEF;
    vals[2] = 32'h0000_00A5;
    vals[3] = 32'h8000_0001;
    for (int i = 0; i < N_CNT; i++) begin
      reg_write(reg_addr_t'(i), vals[i]);
    end
    read_all();
    // Three flags on top of 0xFFFFFFFE wrap the counter to one
    reg_write(REG_DATA_CORR, 32'hFFFF_FFFE);
    e           = '0;
    e.data_corr = data_err_t'(3'b111);
    apply_flags(e);
    clear_flags();
    reg_access(1'b0, REG_DATA_CORR, '0, rd);
    check_val("data_corr count after wrap", 32'h0000_0001, rd);
    // Writing zero clears every counter
    for (int i = 0; i < N_CNT; i++) begin
      reg_write(reg_addr_t'(i), '0);
    end
    read_all();
  endtask

  task automatic test_backpressure();
    reg_req_t    r;
    ecc_err_t    e;
    err_cnt_t    held;
    logic [31:0] rnd_u;
    logic [31:0] rnd_m;
    int unsigned lat;
    r       = '0;
    r.req   = 1'b1;
    r.addr  = REG_DATA_UNCORR;
    @(negedge clk);
    @(posedge clk);
    reg_req <= r;
    wait_ack(1'b1, lat);
    held = reg_rsp.rdata;
    check_val("rdata at ack", exp_cnt[REG_DATA_UNCORR], held);
    // Req stays high, flags keep arriving and must be counted
    repeat (HOLD_CYCLES) begin
      rnd_u         = $random(seed);
      rnd_m         = $random(seed);
      e             = '0;
      e.data_uncorr = rnd_u[DATA_ERR_W-1:0];
      e.meta_corr   = rnd_m[META_ERR_W-1:0];
      apply_flags(e);
      @(negedge clk);
      if (reg_rsp.ack !== 1'b1) begin
        $display("Handshake error: ack dropped while req was still held");
        errors++;
      end
      check_val("rdata during hold", held, reg_rsp.rdata);
    end
    clear_flags();
    @(posedge clk);
    reg_req <= '0;
    wait_ack(1'b0, lat);
    read_all();
  endtask

  initial begin
    seed      = 19;
    errors    = 0;
    checks    = 0;
    cycle_cnt = 0;
    rst       = 1'b1;
    reg_req   = '0;
    err       = '0;
    for (int i = 0; i < N_CNT; i++) begin
      exp_cnt[i] = '0;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    test_reset();
    test_data_random();
    test_meta_random();
    test_loads();
    test_backpressure();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
